// File: dma_noc_resp_top.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_wb_if.sv
rtl/dma_packet_buffer.sv
rtl/dma_wb_resp_writer.sv
rtl/dma_local_mem.sv
rtl/dma_req_table.sv
rtl/dma_noc_resp_top.sv
testbench/tb_dma_noc_resp.sv

// File: rtl/dma_local_mem.sv
/* Tile-local word memory. Written by the response writer over Wishbone,
   read by the tile processor through a registered read port. */
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_local_mem
  import dma_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  dma_wb_if.slave  wb,
  input  mem_idx_t rd_addr_i,
  output data_t    rd_data_o
);

  data_t    mem [`MEM_WORDS];
  logic     ack_q;
  mem_idx_t wr_idx;
  logic     wr_en;

  // Byte address to word index
  assign wr_idx = wb.adr[9:2];

  // Whole-word writes only, linear bursts only
  assign wr_en = ack_q & wb.we & (&wb.sel) & (wb.bte == 2'b00);

  assign wb.ack = ack_q;

  ////////////////////////////////////////////////////////////
  // Wishbone slave

  // One ack per beat, then low for a cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb.cyc & wb.stb & ~ack_q;
    end
  end

  // Master still holds adr and data during the ack cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wb.dat_w;
    end
  end

  ////////////////////////////////////////////////////////////
  // Processor read port

  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: rtl/dma_macros.svh
/* Flit layout, header fields and sizing for the DMA response path.
   Included by the package and by every RTL module that decodes flits. */
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Flit framing: 2 type bits on top of a 32-bit payload
`define FLIT_WIDTH         34
`define FLIT_TYPE_MSB      33
`define FLIT_TYPE_LSB      32
`define FLIT_CONTENT_MSB   31
`define FLIT_CONTENT_LSB   0

// Flit type codes
`define FLIT_TYPE_SINGLE   2'b11
`define FLIT_TYPE_FIRST    2'b01
`define FLIT_TYPE_MIDDLE   2'b00
`define FLIT_TYPE_LAST     2'b10

// Header flit fields, inside the content
`define PACKET_TYPE_MSB    31
`define PACKET_TYPE_LSB    30
`define PACKET_TYPE_L2R_RESP 2'b10
`define PACKET_TYPE_R2L_RESP 2'b11
`define PACKET_RESP_LAST   29
`define PACKET_ID_MSB      1
`define PACKET_ID_LSB      0

// Sizing
`define TABLE_ENTRIES      4
`define NOC_PACKET_SIZE    16
`define MEM_WORDS          256

`endif

// File: rtl/dma_noc_resp_top.sv
/* DMA response path top level. NoC flits enter the packet buffer, the writer
   drains them into local memory and retires entries in the request table. */
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_noc_resp_top
  import dma_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  // NoC response input
  input  flit_t    noc_in_flit_i,
  input  logic     noc_in_valid_i,
  output logic     noc_in_ready_o,
  // Request table
  input  logic     alloc_en_i,
  input  resp_id_t alloc_id_i,
  output pending_t pending_o,
  output logic     done_en_o,
  output resp_id_t done_id_o,
  // Processor read port
  input  mem_idx_t rd_addr_i,
  output data_t    rd_data_o
);

  ////////////////////////////////////////////////////////////
  // Internal connections

  flit_t    buf_flit;
  logic     buf_valid;
  logic     buf_ready;
  logic     done_en;
  resp_id_t done_id;

  dma_wb_if wb_bus ();

  assign done_en_o = done_en;
  assign done_id_o = done_id;

  dma_packet_buffer dma_packet_buffer_inst (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_in_flit_i),
    .in_valid_i  (noc_in_valid_i),
    .in_ready_o  (noc_in_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_wb_resp_writer dma_wb_resp_writer_inst (
    .clk         (clk),
    .rst         (rst),
    .buf_flit_i  (buf_flit),
    .buf_valid_i (buf_valid),
    .buf_ready_o (buf_ready),
    .wb          (wb_bus.master),
    .done_en_o   (done_en),
    .done_id_o   (done_id)
  );

  dma_local_mem dma_local_mem_inst (
    .clk       (clk),
    .rst       (rst),
    .wb        (wb_bus.slave),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

  dma_req_table dma_req_table_inst (
    .clk        (clk),
    .rst        (rst),
    .alloc_en_i (alloc_en_i),
    .alloc_id_i (alloc_id_i),
    .done_en_i  (done_en),
    .done_id_i  (done_id),
    .pending_o  (pending_o)
  );

endmodule

// File: rtl/dma_packet_buffer.sv
/* Flit FIFO in front of the response writer. Flits are only released once
   the complete packet they belong to is stored, so the writer never stalls mid-packet. */
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_packet_buffer
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t in_flit_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output flit_t out_flit_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  localparam int DEPTH = `NOC_PACKET_SIZE;
  localparam int PTR_W = $clog2(DEPTH);

  ////////////////////////////////////////////////////////////
  // Storage and pointers

  flit_t            fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   flit_cnt;
  logic [PTR_W:0]   pkt_cnt;

  logic push;
  logic pop;
  logic push_eop;
  logic pop_eop;

  // Full is the only back-pressure condition
  assign in_ready_o = (flit_cnt != (PTR_W+1)'(DEPTH));
  assign push       = in_valid_i & in_ready_o;

  // Visible only while a whole packet sits in the FIFO
  assign out_valid_o = (flit_cnt != '0) & (pkt_cnt != '0);
  assign out_flit_o  = fifo_mem[rd_ptr];
  assign pop         = out_valid_o & out_ready_i;

  // End of packet is a last or single flit
  assign push_eop = (in_flit_i[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] == `FLIT_TYPE_LAST) |
                    (in_flit_i[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] == `FLIT_TYPE_SINGLE);
  assign pop_eop  = (out_flit_o[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] == `FLIT_TYPE_LAST) |
                    (out_flit_o[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] == `FLIT_TYPE_SINGLE);

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= in_flit_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointer and counter update

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      flit_cnt <= '0;
      pkt_cnt  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        flit_cnt <= flit_cnt + 1'b1;
      end else if (pop && !push) begin
        flit_cnt <= flit_cnt - 1'b1;
      end
      // Complete packets stored
      if ((push && push_eop) && !(pop && pop_eop)) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end else if ((pop && pop_eop) && !(push && push_eop)) begin
        pkt_cnt <= pkt_cnt - 1'b1;
      end
    end
  end

endmodule

// File: rtl/dma_pkg.sv
/* Shared types for the DMA response path: flit, address, data, id vectors
   and the writer FSM states. */
`include "dma_macros.svh"

package dma_pkg;

  // Raw flit as it travels on the NoC
  typedef logic [`FLIT_WIDTH-1:0] flit_t;

  // Wishbone side
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One id per request-table entry
  typedef logic [$clog2(`TABLE_ENTRIES)-1:0] resp_id_t;
  typedef logic [`TABLE_ENTRIES-1:0] pending_t;

  // Word index into local memory
  typedef logic [$clog2(`MEM_WORDS)-1:0] mem_idx_t;

  // Response writer FSM
  typedef enum logic [1:0] {
    IDLE,
    GET_SIZE,
    GET_ADDR,
    DATA
  } writer_state_t;

endpackage

// File: rtl/dma_req_table.sv
/* Request table. One pending bit per DMA request id, set on allocation
   and cleared when the writer reports the response done. */
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_req_table
  import dma_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     alloc_en_i,
  input  resp_id_t alloc_id_i,
  input  logic     done_en_i,
  input  resp_id_t done_id_i,
  output pending_t pending_o
);

  pending_t pending_q;

  assign pending_o = pending_q;

  // Clear first, set second, so alloc wins on the same id
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
    end else begin
      if (done_en_i) begin
        pending_q[done_id_i] <= 1'b0;
      end
      if (alloc_en_i) begin
        pending_q[alloc_id_i] <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/dma_wb_if.sv
/* Wishbone bus between the response writer (master) and local memory (slave).
   Word writes only, linear bursts. */
`timescale 1ns/1ps

interface dma_wb_if
  import dma_pkg::*;
();

  addr_t       adr;
  data_t       dat_w;
  logic [3:0]  sel;
  logic        we;
  logic        cyc;
  logic        stb;
  // Burst type, 3'b010 incrementing or 3'b111 end of burst
  logic [2:0]  cti;
  logic [1:0]  bte;
  logic        ack;

  // Master holds request signals until ack
  modport master (
    output adr, dat_w, sel, we, cyc, stb, cti, bte,
    input  ack
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb, cti, bte,
    output ack
  );

endinterface

// File: rtl/dma_wb_resp_writer.sv
/* Response writer FSM. Decodes buffered response packets, retires L2R
   completions and writes R2L data words to local memory as Wishbone bursts. */
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_wb_resp_writer
  import dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  flit_t       buf_flit_i,
  input  logic        buf_valid_i,
  output logic        buf_ready_o,
  dma_wb_if.master    wb,
  output logic        done_en_o,
  output resp_id_t    done_id_o
);

  ////////////////////////////////////////////////////////////
  // State and header registers

  writer_state_t state_q;
  writer_state_t state_d;
  addr_t         addr_q;
  addr_t         addr_d;
  resp_id_t      id_q;
  resp_id_t      id_d;
  logic          resp_last_q;
  logic          resp_last_d;

  logic [1:0]    pkt_type;
  logic          last_flit;

  // Header decode, only meaningful in IDLE
  assign pkt_type = buf_flit_i[`PACKET_TYPE_MSB:`PACKET_TYPE_LSB];

  assign last_flit = (buf_flit_i[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] == `FLIT_TYPE_LAST) |
                     (buf_flit_i[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] == `FLIT_TYPE_SINGLE);

  // Bus fields that follow registers or the current flit
  assign wb.adr   = addr_q;
  assign wb.dat_w = buf_flit_i[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB];
  // Whole words, linear bursts
  assign wb.sel   = 4'hf;
  assign wb.bte   = 2'b00;
  // End the burst on the packet's last flit
  assign wb.cti   = last_flit ? 3'b111 : 3'b010;

  ////////////////////////////////////////////////////////////
  // Next state logic

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    id_d        = id_q;
    resp_last_d = resp_last_q;
    buf_ready_o = 1'b0;
    wb.cyc      = 1'b0;
    wb.stb      = 1'b0;
    wb.we       = 1'b0;
    done_en_o   = 1'b0;
    done_id_o   = id_q;

    case (state_q)
      IDLE: begin
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          id_d        = buf_flit_i[`PACKET_ID_MSB:`PACKET_ID_LSB];
          resp_last_d = buf_flit_i[`PACKET_RESP_LAST];
          if (pkt_type == `PACKET_TYPE_L2R_RESP) begin
            // Completion retires right away, with the header id
            done_en_o = 1'b1;
            done_id_o = buf_flit_i[`PACKET_ID_MSB:`PACKET_ID_LSB];
          end else if (pkt_type == `PACKET_TYPE_R2L_RESP) begin
            state_d = GET_SIZE;
          end
          // Unknown packet types are dropped
        end
      end
      GET_SIZE: begin
        // Size is implied by the last flit, so skip it
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          state_d = GET_ADDR;
        end
      end
      GET_ADDR: begin
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          addr_d  = buf_flit_i[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB];
          state_d = DATA;
        end
      end
      DATA: begin
        wb.cyc = 1'b1;
        wb.stb = 1'b1;
        wb.we  = 1'b1;
        // Flit consumed with the beat's ack
        if (wb.ack) begin
          buf_ready_o = 1'b1;
          addr_d      = addr_q + 32'd4;
          if (last_flit) begin
            state_d = IDLE;
            if (resp_last_q) begin
              done_en_o = 1'b1;
            end
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      resp_last_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      resp_last_q <= resp_last_d;
    end
  end

  // Burst address and response id, loaded from the packet flits
  always_ff @(posedge clk) begin
    addr_q <= addr_d;
    id_q   <= id_d;
  end

endmodule

// File: testbench/tb_dma_noc_resp.sv
/* Table-driven testbench for the DMA response path. Sends response packets,
   mirrors written words in a model memory and checks done pulses and pending bits. */
`timescale 1ns/1ps
`include "dma_macros.svh"

module tb_dma_noc_resp
  import dma_pkg::*;
();

  localparam int NUM_TESTS = 7;
  localparam int TIMEOUT   = 2000;

  logic clk = 1'b0;
  logic rst;
  flit_t noc_in_flit_i;
  logic noc_in_valid_i;
  logic noc_in_ready_o;
  logic alloc_en_i;
  logic done_en_o;
  resp_id_t alloc_id_i;
  resp_id_t done_id_o;
  pending_t pending_o;
  pending_t exp_pending;
  mem_idx_t rd_addr_i;
  data_t rd_data_o;

  // Test table, one column per field
  string      t_name  [NUM_TESTS];
  logic [1:0] t_type  [NUM_TESTS];
  resp_id_t   t_id    [NUM_TESTS];
  logic       t_last  [NUM_TESTS];
  int         t_start [NUM_TESTS];
  int         t_len   [NUM_TESTS];
  logic       t_b2b   [NUM_TESTS];

  data_t model_mem [`MEM_WORDS];
  resp_id_t done_q[$];
  resp_id_t exp_done[$];
  logic [31:0] rng;
  logic saw_stall;

  dma_noc_resp_top dma_noc_resp_top_inst (.*);

  always #50 clk = ~clk;

  // Done pulse monitor
  always @(posedge clk) begin
    if (!rst && done_en_o) done_q.push_back(done_id_o);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  task automatic set_entry(input int i, input string n, input logic [1:0] ty, input resp_id_t id,
                           input logic last, input int start, input int len, input logic b2b);
    t_name[i]  = n;
    t_type[i]  = ty;
    t_id[i]    = id;
    t_last[i]  = last;
    t_start[i] = start;
    t_len[i]   = len;
    t_b2b[i]   = b2b;
  endtask

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act));
    end
  endtask

  // Holds the flit until the buffer takes it
  task automatic send_flit(input logic [1:0] ftype, input logic [31:0] content);
    int cnt;
    cnt = 0;
    noc_in_flit_i  = {ftype, content};
    noc_in_valid_i = 1'b1;
    while (!noc_in_ready_o) begin
      saw_stall = 1'b1;
      tick();
      cnt++;
      if (cnt > TIMEOUT) report_failure("Timeout: buffer never accepted a flit");
    end
    tick();
    noc_in_valid_i = 1'b0;
  endtask

  task automatic send_packet(input int i);
    logic [31:0] word;
    if (t_type[i] == `PACKET_TYPE_L2R_RESP) begin
      send_flit(`FLIT_TYPE_SINGLE, {t_type[i], t_last[i], 27'd0, t_id[i]});
    end else begin
      send_flit(`FLIT_TYPE_FIRST, {t_type[i], t_last[i], 27'd0, t_id[i]});
      send_flit(`FLIT_TYPE_MIDDLE, t_len[i]);
      send_flit(`FLIT_TYPE_MIDDLE, t_start[i] * 4);
      for (int w = 0; w < t_len[i]; w++) begin
        rng  = xorshift32(rng);
        word = rng;
        model_mem[t_start[i] + w] = word;
        send_flit((w == t_len[i] - 1) ? `FLIT_TYPE_LAST : `FLIT_TYPE_MIDDLE, word);
      end
    end
  endtask

  // Completion without a done pulse shows up as the last word in memory
  task automatic wait_done_or_word(input int i);
    int cnt;
    cnt = 0;
    while ((exp_done.size() > done_q.size()) ||
           ((exp_done.size() == done_q.size()) && t_len[i] > 0 &&
            rd_data_o !== model_mem[t_start[i] + t_len[i] - 1])) begin
      rd_addr_i = t_start[i] + t_len[i] - 1;
      tick();
      cnt++;
      if (cnt > TIMEOUT) report_failure($sformatf("Timeout: %s did not complete", t_name[i]));
    end
  endtask

  // Reads back every word written so far, one cycle latency
  task automatic check_memory(input int upto);
    for (int e = 0; e <= upto; e++) begin
      for (int w = 0; w < t_len[e]; w++) begin
        rd_addr_i = t_start[e] + w;
        tick();
        check_value(t_name[e], $sformatf("word %0d", t_start[e] + w),
                    model_mem[t_start[e] + w], rd_data_o);
      end
    end
  endtask

  initial begin
    rng = 32'h6601;
    rst = 1'b1;
    noc_in_flit_i = '0;
    noc_in_valid_i = 1'b0;
    alloc_en_i = 1'b0;
    alloc_id_i = '0;
    rd_addr_i = '0;
    saw_stall = 1'b0;
    exp_pending = '0;
    set_entry(0, "l2r_done",   `PACKET_TYPE_L2R_RESP, 2'd1, 1'b1, 0,   0, 1'b0);
    set_entry(1, "r2l_write",  `PACKET_TYPE_R2L_RESP, 2'd2, 1'b1, 8,   4, 1'b0);
    set_entry(2, "multi_pkt1", `PACKET_TYPE_R2L_RESP, 2'd3, 1'b0, 32,  3, 1'b0);
    set_entry(3, "multi_pkt2", `PACKET_TYPE_R2L_RESP, 2'd3, 1'b1, 40,  5, 1'b0);
    set_entry(4, "bp_a",       `PACKET_TYPE_R2L_RESP, 2'd0, 1'b1, 64,  8, 1'b1);
    set_entry(5, "bp_b",       `PACKET_TYPE_R2L_RESP, 2'd1, 1'b1, 96,  8, 1'b1);
    set_entry(6, "bp_c",       `PACKET_TYPE_R2L_RESP, 2'd2, 1'b1, 128, 6, 1'b1);
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;
    check_value("reset", "pending", '0, pending_o);
    check_value("reset", "done_en", 1'b0, done_en_o);
    check_value("reset", "ready", 1'b1, noc_in_ready_o);

    ////////////////////////////////////////////////////////////
    // Table loop
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (i == 0 || !t_b2b[i - 1]) saw_stall = 1'b0;
      alloc_en_i = 1'b1;
      alloc_id_i = t_id[i];
      tick();
      alloc_en_i = 1'b0;
      exp_pending[t_id[i]] = 1'b1;
      send_packet(i);
      if (t_type[i] == `PACKET_TYPE_L2R_RESP || t_last[i]) begin
        exp_done.push_back(t_id[i]);
        exp_pending[t_id[i]] = 1'b0;
      end
      // Back-to-back packets are checked together once the group ends
      if (!t_b2b[i] || i == NUM_TESTS - 1 || !t_b2b[i + 1]) begin
        wait_done_or_word(i);
        tick();
        check_value(t_name[i], "done count", exp_done.size(), done_q.size());
        for (int k = 0; k < exp_done.size(); k++) begin
          check_value(t_name[i], "done id", exp_done[k], done_q[k]);
        end
        check_value(t_name[i], "pending", exp_pending, pending_o);
        if (t_b2b[i]) check_value(t_name[i], "ready dropped", 1'b1, saw_stall);
        check_memory(i);
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule
